//--- src/procPkg.sv
//############################
// Widths, opcodes and ALU operations shared by every pipeline stage
//############################
package procPkg;

   localparam int WordBits    = 16;
   localparam int RegAddrBits = 3;

   // Default depth of the internal data memory
   localparam int DmemWords = 256;

   typedef logic [WordBits-1:0]    word_t;
   typedef logic [RegAddrBits-1:0] regAddr_t;

   // Instruction field positions
   localparam int OpMsb   = 15;
   localparam int OpLsb   = 11;
   localparam int RsMsb   = 10;
   localparam int RsLsb   = 8;
   localparam int RtMsb   = 7;
   localparam int RtLsb   = 5;
   localparam int RdMsb   = 4;
   localparam int RdLsb   = 2;
   localparam int Imm5Msb = 4;
   localparam int Off8Msb = 7;

   // Codes not listed here are illegal
   typedef enum logic [OpMsb-OpLsb:0] {
      OpHalt = 5'b00000,
      OpNop  = 5'b00001,
      OpAddi = 5'b01000,
      OpBeqz = 5'b01100,
      OpSt   = 5'b10000,
      OpLd   = 5'b10001,
      OpAdd  = 5'b11000,
      OpSub  = 5'b11001,
      OpAnd  = 5'b11010,
      OpXor  = 5'b11011
   } opcode_t;

   typedef enum logic [1:0] {
      AluAdd,
      AluSub,
      AluAnd,
      AluXor
   } aluOp_t;

endpackage

//--- src/decodeBus.sv
//############################
// Decoded instruction bundle, decode drives it and execute reads it
//############################
`timescale 1ns/10ps

interface decodeBus
   import procPkg::*;
();

   logic     valid;
   aluOp_t   aluOp;
   logic     useImm;
   logic     isLoad;
   logic     isStore;
   logic     isBranch;
   logic     isHalt;
   logic     regWrite;
   regAddr_t destAddr;
   word_t    rsData;
   word_t    rtData;
   word_t    imm;
   // Address of the following instruction
   word_t    pcNext;

   modport src (
      output valid, aluOp, useImm, isLoad, isStore, isBranch, isHalt,
      output regWrite, destAddr, rsData, rtData, imm, pcNext
   );

   modport dst (
      input valid, aluOp, useImm, isLoad, isStore, isBranch, isHalt,
      input regWrite, destAddr, rsData, rtData, imm, pcNext
   );

endinterface

//--- src/fetch.sv
//############################
// Program counter and IF/ID register over a one-cycle instruction ROM
//############################
`timescale 1ns/10ps

module fetch import procPkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  rstN,
   input  logic  stall,
   input  logic  flush,
   input  logic  fetchStop,
   input  word_t branchTarget,
   input  word_t imemData,
   output word_t imemAddr,
   output word_t instr,
   output word_t pcNext,
   output logic  instrValid
);

   word_t pc;
   // Word on imemData belongs to the address presented at the last edge
   logic  flightValid;
   word_t flightPcNext;
   // One entry kept while decode is stalled
   logic  holdValid;
   word_t holdInstr;
   word_t holdPcNext;

   assign imemAddr = pc;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc          <= RESET_PC;
         flightValid <= 1'b0;
         holdValid   <= 1'b0;
         instrValid  <= 1'b0;
      end else if (flush) begin
         // Redirect and drop everything younger than the branch
         pc          <= branchTarget;
         flightValid <= 1'b0;
         holdValid   <= 1'b0;
         instrValid  <= 1'b0;
      end else if (fetchStop) begin
         flightValid <= 1'b0;
         holdValid   <= 1'b0;
         instrValid  <= 1'b0;
      end else if (stall) begin
         flightValid <= 1'b1;
         holdValid   <= holdValid | flightValid;
      end else begin
         pc          <= pc + 1'b1;
         flightValid <= 1'b1;
         holdValid   <= 1'b0;
         instrValid  <= holdValid | flightValid;
      end
   end

   always_ff @(posedge clk) begin
      flightPcNext <= pc + 1'b1;
      if (stall && !holdValid) begin
         holdInstr  <= imemData;
         holdPcNext <= flightPcNext;
      end
      // Held word is older than the one in flight
      if (!stall) begin
         instr  <= holdValid ? holdInstr : imemData;
         pcNext <= holdValid ? holdPcNext : flightPcNext;
      end
   end

endmodule

//--- src/decode.sv
//############################
// Instruction decode, register file and the ID/EX register on decodeBus
//############################
`timescale 1ns/10ps

module decode import procPkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  logic     stall,
   input  logic     flush,
   input  word_t    instr,
   input  logic     instrValid,
   input  word_t    pcNext,
   input  logic     wbEn,
   input  regAddr_t wbAddr,
   input  word_t    wbData,
   output logic     illegal,
   decodeBus.src    bus
);

   opcode_t  op;
   regAddr_t rs;
   regAddr_t rt;
   logic     legal;
   aluOp_t   aluOp;
   logic     useImm;
   logic     isLoad;
   logic     isStore;
   logic     isBranch;
   logic     isHalt;
   logic     regWrite;
   regAddr_t destAddr;
   word_t    imm;
   word_t    regs [2**RegAddrBits];
   word_t    rsData;
   word_t    rtData;
   logic     bubble;

   assign op = opcode_t'(instr[OpMsb:OpLsb]);
   assign rs = instr[RsMsb:RsLsb];
   assign rt = instr[RtMsb:RtLsb];

   // Illegal codes leave every control bit low and act as NOP
   always_comb begin
      legal    = 1'b1;
      aluOp    = AluAdd;
      useImm   = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      isBranch = 1'b0;
      isHalt   = 1'b0;
      regWrite = 1'b0;
      destAddr = instr[RdMsb:RdLsb];
      case (op)
         OpAdd: regWrite = 1'b1;
         OpSub: begin
            aluOp    = AluSub;
            regWrite = 1'b1;
         end
         OpAnd: begin
            aluOp    = AluAnd;
            regWrite = 1'b1;
         end
         OpXor: begin
            aluOp    = AluXor;
            regWrite = 1'b1;
         end
         OpAddi: begin
            useImm   = 1'b1;
            regWrite = 1'b1;
            destAddr = rt;
         end
         OpLd: begin
            useImm   = 1'b1;
            isLoad   = 1'b1;
            regWrite = 1'b1;
            destAddr = rt;
         end
         OpSt: begin
            useImm  = 1'b1;
            isStore = 1'b1;
         end
         OpBeqz: isBranch = 1'b1;
         OpHalt: isHalt = 1'b1;
         OpNop:  legal = 1'b1;
         default: legal = 1'b0;
      endcase
   end

   // Branch offset is 8 bits, everything else uses imm5
   assign imm = (op == OpBeqz) ?
                {{(WordBits-Off8Msb-1){instr[Off8Msb]}}, instr[Off8Msb:0]} :
                {{(WordBits-Imm5Msb-1){instr[Imm5Msb]}}, instr[Imm5Msb:0]};

   // Reads see a write landing on the same edge
   assign rsData = (wbEn && wbAddr == rs) ? wbData : regs[rs];
   assign rtData = (wbEn && wbAddr == rt) ? wbData : regs[rt];

   always_ff @(posedge clk) begin
      if (wbEn) regs[wbAddr] <= wbData;
   end

   assign illegal = instrValid & ~legal & ~stall & ~flush;
   assign bubble  = ~instrValid | stall | flush;

   always_ff @(posedge clk) begin
      if (!rstN || bubble) begin
         bus.valid    <= 1'b0;
         bus.regWrite <= 1'b0;
         bus.isLoad   <= 1'b0;
         bus.isStore  <= 1'b0;
         bus.isBranch <= 1'b0;
         bus.isHalt   <= 1'b0;
      end else begin
         bus.valid    <= 1'b1;
         bus.regWrite <= regWrite;
         bus.isLoad   <= isLoad;
         bus.isStore  <= isStore;
         bus.isBranch <= isBranch;
         bus.isHalt   <= isHalt;
      end
   end

   always_ff @(posedge clk) begin
      bus.aluOp    <= aluOp;
      bus.useImm   <= useImm;
      bus.destAddr <= destAddr;
      bus.rsData   <= rsData;
      bus.rtData   <= rtData;
      bus.imm      <= imm;
      bus.pcNext   <= pcNext;
   end

endmodule

//--- src/execute.sv
//############################
// ALU, BEQZ resolution and the EX/MEM register
//############################
`timescale 1ns/10ps

module execute import procPkg::*; (
   input  logic     clk,
   input  logic     rstN,
   decodeBus.dst    bus,
   output logic     takeBranch,
   output word_t    branchTarget,
   output regAddr_t exAddr,
   output logic     exRegWrite,
   output word_t    aluOut,
   output word_t    storeData,
   output logic     memRead,
   output logic     memWrite,
   output logic     memHalt,
   output logic     memValid
);

   word_t opB;
   word_t aluRes;

   assign opB = bus.useImm ? bus.imm : bus.rtData;

   // Loads and stores use AluAdd for base plus offset
   always_comb begin
      case (bus.aluOp)
         AluAdd:  aluRes = bus.rsData + opB;
         AluSub:  aluRes = bus.rsData - opB;
         AluAnd:  aluRes = bus.rsData & opB;
         AluXor:  aluRes = bus.rsData ^ opB;
         default: aluRes = bus.rsData + opB;
      endcase
   end

   // BEQZ tests rs against zero
   assign takeBranch   = bus.valid & bus.isBranch & (bus.rsData == '0);
   assign branchTarget = bus.pcNext + bus.imm;

   // The branch itself moves on as an entry that writes nothing
   always_ff @(posedge clk) begin
      if (!rstN) begin
         memValid   <= 1'b0;
         exRegWrite <= 1'b0;
         memRead    <= 1'b0;
         memWrite   <= 1'b0;
         memHalt    <= 1'b0;
      end else begin
         memValid   <= bus.valid;
         exRegWrite <= bus.valid & bus.regWrite;
         memRead    <= bus.valid & bus.isLoad;
         memWrite   <= bus.valid & bus.isStore;
         memHalt    <= bus.valid & bus.isHalt;
      end
   end

   always_ff @(posedge clk) begin
      exAddr    <= bus.destAddr;
      aluOut    <= aluRes;
      storeData <= bus.rtData;
   end

endmodule

//--- src/memory.sv
//############################
// Data memory, MEM/WB register and writeback select
//############################
`timescale 1ns/10ps

module memory import procPkg::*; #(
   parameter int DMEM_DEPTH = DmemWords
) (
   input  logic     clk,
   input  logic     rstN,
   input  regAddr_t exAddr,
   input  logic     exRegWrite,
   input  word_t    aluOut,
   input  word_t    storeData,
   input  logic     memRead,
   input  logic     memWrite,
   input  logic     memHalt,
   input  logic     memValid,
   output logic     wbEn,
   output regAddr_t wbAddr,
   output word_t    wbData,
   output logic     wbHalt
);

   localparam int AddrBits = $clog2(DMEM_DEPTH);

   word_t               dmem [DMEM_DEPTH];
   logic [AddrBits-1:0] dmemIdx;
   logic                wbIsLoad;
   word_t               wbAlu;
   word_t               wbLoad;

   // Word address wraps at the memory depth
   assign dmemIdx = AddrBits'(int'(aluOut) % DMEM_DEPTH);

   always_ff @(posedge clk) begin
      if (memValid && memWrite) dmem[dmemIdx] <= storeData;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         wbEn     <= 1'b0;
         wbHalt   <= 1'b0;
         wbIsLoad <= 1'b0;
      end else begin
         wbEn     <= memValid & exRegWrite;
         wbHalt   <= memValid & memHalt;
         wbIsLoad <= memValid & memRead;
      end
   end

   // Synchronous read lands in MEM/WB with the ALU result
   always_ff @(posedge clk) begin
      wbAddr <= exAddr;
      wbAlu  <= aluOut;
      wbLoad <= dmem[dmemIdx];
   end

   assign wbData = wbIsLoad ? wbLoad : wbAlu;

endmodule

//--- src/hazardCtrl.sv
//############################
// Stall, flush, halt and illegal-opcode control for the pipeline
//############################
`timescale 1ns/10ps

module hazardCtrl import procPkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  logic     ifValid,
   input  opcode_t  ifOp,
   input  regAddr_t ifRs,
   input  regAddr_t ifRt,
   input  regAddr_t idExAddr,
   input  logic     idExRegWrite,
   input  regAddr_t exMemAddr,
   input  logic     exMemRegWrite,
   input  regAddr_t memWbAddr,
   input  logic     memWbRegWrite,
   input  logic     takeBranch,
   input  logic     illegal,
   input  logic     wbHalt,
   output logic     stall,
   output logic     flush,
   output logic     fetchStop,
   output logic     halted,
   output logic     err
);

   logic useRs;
   logic useRt;
   logic decodeHalt;
   logic haltSeen;
   logic haltedQ;

   // True while an older instruction still has to write src
   function automatic logic pending(regAddr_t src);
      logic hit;
      hit = (idExRegWrite && idExAddr == src) ||
            (exMemRegWrite && exMemAddr == src) ||
            (memWbRegWrite && memWbAddr == src);
      return hit;
   endfunction

   // Source registers actually read by the decoding instruction
   always_comb begin
      useRs = 1'b0;
      useRt = 1'b0;
      case (ifOp)
         OpAdd, OpSub, OpAnd, OpXor, OpSt: begin
            useRs = 1'b1;
            useRt = 1'b1;
         end
         OpAddi, OpLd, OpBeqz: useRs = 1'b1;
         default: useRt = 1'b0;
      endcase
   end

   assign stall = ifValid & ((useRs & pending(ifRs)) | (useRt & pending(ifRt)));
   assign flush = takeBranch;

   // A HALT killed by a taken branch must not stop fetch
   assign decodeHalt = ifValid & (ifOp == OpHalt) & ~flush;
   assign fetchStop  = haltSeen | decodeHalt;
   assign halted     = haltedQ | wbHalt;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         haltSeen <= 1'b0;
         haltedQ  <= 1'b0;
         err      <= 1'b0;
      end else begin
         haltSeen <= haltSeen | decodeHalt;
         haltedQ  <= haltedQ | wbHalt;
         err      <= err | illegal;
      end
   end

endmodule

//--- src/proc.sv
//############################
// Five-stage pipeline top, instruction ROM sits outside on imemAddr/imemData
//############################
`timescale 1ns/10ps

module proc import procPkg::*; #(
   parameter int    DMEM_DEPTH = DmemWords,
   parameter word_t RESET_PC   = '0
) (
   input  logic     clk,
   input  logic     rstN,
   input  word_t    imemData,
   output word_t    imemAddr,
   output logic     wbEn,
   output regAddr_t wbAddr,
   output word_t    wbData,
   output logic     halted,
   output logic     err
);

   logic     stall, flush, fetchStop, illegal, wbHalt;
   word_t    ifInstr, ifPcNext;
   logic     ifValid;
   opcode_t  ifOp;
   logic     takeBranch;
   word_t    branchTarget;
   regAddr_t exAddr;
   logic     exRegWrite, memRead, memWrite, memHalt, memValid;
   word_t    aluOut, storeData;

   decodeBus idEx ();

   assign ifOp = opcode_t'(ifInstr[OpMsb:OpLsb]);

   fetch #(.RESET_PC(RESET_PC)) i_fetch (
      .clk, .rstN, .stall, .flush, .fetchStop, .branchTarget, .imemData, .imemAddr,
      .instr(ifInstr), .pcNext(ifPcNext), .instrValid(ifValid)
   );

   decode i_decode (
      .clk, .rstN, .stall, .flush, .instr(ifInstr), .instrValid(ifValid),
      .pcNext(ifPcNext), .wbEn, .wbAddr, .wbData, .illegal, .bus(idEx)
   );

   execute i_execute (
      .clk, .rstN, .bus(idEx), .takeBranch, .branchTarget, .exAddr, .exRegWrite,
      .aluOut, .storeData, .memRead, .memWrite, .memHalt, .memValid
   );

   memory #(.DMEM_DEPTH(DMEM_DEPTH)) i_memory (
      .clk, .rstN, .exAddr, .exRegWrite, .aluOut, .storeData, .memRead, .memWrite,
      .memHalt, .memValid, .wbEn, .wbAddr, .wbData, .wbHalt
   );

   hazardCtrl i_hazardCtrl (
      .clk, .rstN, .ifValid, .ifOp,
      .ifRs(ifInstr[RsMsb:RsLsb]), .ifRt(ifInstr[RtMsb:RtLsb]),
      .idExAddr(idEx.destAddr), .idExRegWrite(idEx.regWrite),
      .exMemAddr(exAddr), .exMemRegWrite(exRegWrite),
      .memWbAddr(wbAddr), .memWbRegWrite(wbEn),
      .takeBranch, .illegal, .wbHalt, .stall, .flush, .fetchStop, .halted, .err
   );

endmodule

//--- bench/proc_asserts.sv
//##############################
// Pipeline control checks, bound into proc from the testbench
//##############################
`timescale 1ns/10ps

module procAsserts import procPkg::*; (
   input logic  clk,
   input logic  rstN,
   input logic  stall,
   input logic  flush,
   input logic  wbEn,
   input logic  halted,
   input logic  err,
   input word_t imemAddr
);

   // Failed assertions, read by the testbench at the end of the run
   int failCount = 0;

   // First cycle out of reset starts from a clean pipeline
   resetClear: assert property (@(posedge clk)
      $rose(rstN) |-> !wbEn && !halted && !err && !stall && !flush)
      else begin
         failCount++;
         $error("Status or control flags not low right after reset");
      end

   haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
      else begin
         failCount++;
         $error("halted dropped before reset");
      end

   // The HALT slot itself and everything after it write nothing
   haltNoWb: assert property (@(posedge clk) disable iff (!rstN) halted |-> !wbEn)
      else begin
         failCount++;
         $error("Writeback seen while halted");
      end

   haltFetch: assert property (@(posedge clk) disable iff (!rstN)
      halted |=> $stable(imemAddr))
      else begin
         failCount++;
         $error("imemAddr moved after halt");
      end

   errSticky: assert property (@(posedge clk) disable iff (!rstN) err |=> err)
      else begin
         failCount++;
         $error("err dropped before reset");
      end

   // Flush leaves a bubble in ID/EX so no branch can resolve next cycle
   flushOnce: assert property (@(posedge clk) disable iff (!rstN) flush |=> !flush)
      else begin
         failCount++;
         $error("flush held for two cycles in a row");
      end

endmodule

//--- bench/procTb.sv
//##############################
// Testbench for the pipelined processor, serves the instruction ROM
// and checks every writeback against a sequential ISA model
//##############################
`timescale 1ns/10ps

module procTb import procPkg::*; ();

   // Small depth so an ADDI pair reaches the aliased word
   localparam int    DmemDepth      = 16;
   localparam word_t ResetPc        = 16'h0008;
   localparam int    Seed           = 57114;
   localparam int    MaxSteps       = 2000;
   localparam int    CyclesPerInstr = 20;
   localparam int    DrainCycles    = 12;

   logic     clk;
   logic     rstN;
   word_t    imemData = '0;
   word_t    imemAddr;
   logic     wbEn;
   regAddr_t wbAddr;
   word_t    wbData;
   logic     halted;
   logic     err;

   word_t    rom [256];
   int       progPtr;
   regAddr_t expAddr [$];
   word_t    expData [$];
   regAddr_t nextAddr;
   word_t    nextData;
   logic     modelErr;
   int       modelSteps;
   int       errCount;
   int       cycles;

   proc #(.DMEM_DEPTH(DmemDepth), .RESET_PC(ResetPc)) i_proc (
      .clk, .rstN, .imemData, .imemAddr, .wbEn, .wbAddr, .wbData, .halted, .err
   );

   bind proc procAsserts i_procAsserts (
      .clk, .rstN, .stall, .flush, .wbEn, .halted, .err, .imemAddr
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // One-cycle synchronous ROM
   always @(posedge clk) begin
      imemData <= rom[imemAddr[7:0]];
   end

   function automatic regAddr_t pickReg();
      return regAddr_t'($urandom_range(7, 0));
   endfunction

   function automatic logic [4:0] pickImm5();
      return 5'($urandom);
   endfunction

   function automatic word_t rType(opcode_t op, regAddr_t rd, regAddr_t rs, regAddr_t rt);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   function automatic word_t iType(opcode_t op, regAddr_t rt, regAddr_t rs, logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t beqzWord(regAddr_t rs, logic [7:0] off);
      return {OpBeqz, rs, off};
   endfunction

   task automatic emit(word_t w);
      rom[progPtr] = w;
      progPtr++;
   endtask

   task automatic emitRandomAlu();
      int kind;
      kind = $urandom_range(4, 0);
      case (kind)
         0: emit(rType(OpAdd, pickReg(), pickReg(), pickReg()));
         1: emit(rType(OpSub, pickReg(), pickReg(), pickReg()));
         2: emit(rType(OpAnd, pickReg(), pickReg(), pickReg()));
         3: emit(rType(OpXor, pickReg(), pickReg(), pickReg()));
         default: emit(iType(OpAddi, pickReg(), pickReg(), pickImm5()));
      endcase
   endtask

   task automatic buildProgram();
      regAddr_t base;
      regAddr_t val;
      regAddr_t dst;
      logic [4:0] off;
      // NOP fill, low byte tags the address
      foreach (rom[i]) rom[i] = {OpNop, 3'b000, 8'(i)};
      progPtr = int'(ResetPc);
      for (int r = 0; r < 8; r++) emit(rType(OpXor, regAddr_t'(r), regAddr_t'(r), regAddr_t'(r)));
      for (int r = 0; r < 8; r++) emit(iType(OpAddi, regAddr_t'(r), regAddr_t'(r), pickImm5()));
      // Back-to-back dependent chain
      emit(iType(OpAddi, 3'd1, 3'd1, pickImm5()));
      emit(rType(OpAdd, 3'd2, 3'd1, 3'd1));
      emit(rType(OpSub, 3'd3, 3'd2, 3'd1));
      emit(rType(OpAnd, 3'd4, 3'd3, 3'd2));
      emit(rType(OpXor, 3'd5, 3'd4, 3'd3));
      emit(iType(OpAddi, 3'd5, 3'd5, pickImm5()));
      repeat (12) emitRandomAlu();
      // Store then load the same word
      repeat (3) begin
         base = pickReg();
         val  = pickReg();
         dst  = pickReg();
         off  = pickImm5();
         emit(iType(OpSt, val, base, off));
         emit(iType(OpLd, dst, base, off));
      end
      // Load through a base one memory depth higher
      emit(iType(OpSt, 3'd3, 3'd6, 5'd2));
      emit(iType(OpAddi, 3'd7, 3'd6, 5'd15));
      emit(iType(OpAddi, 3'd7, 3'd7, 5'd1));
      emit(iType(OpLd, 3'd4, 3'd7, 5'd2));
      // Untaken branch
      emit(rType(OpXor, 3'd6, 3'd6, 3'd6));
      emit(iType(OpAddi, 3'd6, 3'd6, 5'd5));
      emit(beqzWord(3'd6, 8'd2));
      emit(iType(OpAddi, 3'd1, 3'd1, 5'd3));
      emit(iType(OpAddi, 3'd2, 3'd2, 5'd4));
      // Taken over two, then a zero offset that refetches the flushed words
      emit(rType(OpXor, 3'd6, 3'd6, 3'd6));
      emit(beqzWord(3'd6, 8'd2));
      emit(iType(OpAddi, 3'd1, 3'd1, 5'd1));
      emit(iType(OpAddi, 3'd2, 3'd2, 5'd1));
      emit(iType(OpAddi, 3'd3, 3'd3, 5'd1));
      emit(beqzWord(3'd6, 8'd0));
      emit(iType(OpAddi, 3'd4, 3'd4, pickImm5()));
      emit(iType(OpAddi, 3'd5, 3'd5, pickImm5()));
      // Countdown loop, r6 stays zero for the backward branch
      emit(rType(OpXor, 3'd5, 3'd5, 3'd5));
      emit(iType(OpAddi, 3'd5, 3'd5, 5'd3));
      emit(iType(OpAddi, 3'd5, 3'd5, 5'h1f));
      emit(beqzWord(3'd5, 8'd1));
      emit(beqzWord(3'd6, 8'hfd));
      // Illegal opcode
      emit({5'b00111, 11'($urandom)});
      emit(iType(OpAddi, 3'd2, 3'd2, pickImm5()));
      emit(rType(OpAdd, 3'd3, 3'd2, 3'd2));
      repeat (10) emitRandomAlu();
      emit({OpHalt, 11'd0});
      // Never executed
      repeat (4) emit(iType(OpAddi, pickReg(), pickReg(), pickImm5()));
   endtask

   // Sequential ISA model, queues the expected writebacks
   task automatic runModel();
      word_t    regs [8];
      word_t    dmem [DmemDepth];
      word_t    pc;
      word_t    ir;
      word_t    rsVal;
      word_t    rtVal;
      word_t    imm5;
      word_t    off8;
      word_t    ea;
      word_t    result;
      regAddr_t dest;
      logic     done;
      foreach (regs[i]) regs[i] = '0;
      foreach (dmem[i]) dmem[i] = '0;
      pc = ResetPc;
      done = 1'b0;
      modelErr = 1'b0;
      modelSteps = 0;
      while (!done && modelSteps < MaxSteps) begin
         ir = rom[pc[7:0]];
         pc = pc + 16'd1;
         modelSteps++;
         rsVal = regs[ir[10:8]];
         rtVal = regs[ir[7:5]];
         imm5 = {{11{ir[4]}}, ir[4:0]};
         off8 = {{8{ir[7]}}, ir[7:0]};
         ea = rsVal + imm5;
         result = '0;
         case (ir[15:11])
            OpAdd:   result = rsVal + rtVal;
            OpSub:   result = rsVal - rtVal;
            OpAnd:   result = rsVal & rtVal;
            OpXor:   result = rsVal ^ rtVal;
            OpAddi:  result = ea;
            OpLd:    result = dmem[ea % DmemDepth];
            OpSt:    dmem[ea % DmemDepth] = rtVal;
            OpBeqz:  if (rsVal == '0) pc = pc + off8;
            OpHalt:  done = 1'b1;
            OpNop:   ;
            default: modelErr = 1'b1;
         endcase
         dest = (ir[15:11] inside {OpAddi, OpLd}) ? ir[7:5] : ir[4:2];
         if (ir[15:11] inside {OpAdd, OpSub, OpAnd, OpXor, OpAddi, OpLd}) begin
            regs[dest] = result;
            expAddr.push_back(dest);
            expData.push_back(result);
         end
      end
   endtask

   always @(negedge clk) begin
      if (rstN && wbEn) begin
         assert (expAddr.size() > 0) else begin
            errCount++;
            $display("Error at %0t: stray writeback to r%0d after the last expected one",
                     $time, wbAddr);
         end
         if (expAddr.size() > 0) begin
            nextAddr = expAddr.pop_front();
            nextData = expData.pop_front();
            assert (wbAddr == nextAddr) else begin
               errCount++;
               $display("Error at %0t: wbAddr is %0d, expected %0d", $time, wbAddr, nextAddr);
            end
            assert (wbData == nextData) else begin
               errCount++;
               $display("Error at %0t: wbData is %h, expected %h", $time, wbData, nextData);
            end
         end
      end
   end

   initial begin
      rstN = 1'b0;
      errCount = 0;
      cycles = 0;
      void'($urandom(Seed));
      buildProgram();
      runModel();
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
      while (!halted && cycles < CyclesPerInstr * modelSteps) begin
         @(negedge clk);
         cycles++;
      end
      // Anything still in flight would show up as a stray writeback
      if (halted) repeat (DrainCycles) @(negedge clk);
      assert (expAddr.size() == 0) else begin
         errCount++;
         $display("Error at %0t: %0d expected writebacks never appeared",
                  $time, expAddr.size());
      end
      assert (err == modelErr) else begin
         errCount++;
         $display("Error at %0t: err is %b, expected %b", $time, err, modelErr);
      end
      if (!halted) $display("Timeout: processor did not halt within %0d cycles", cycles);
      $display("Result: %0d writeback errors, %0d assertion failures, %0d cycles",
               errCount, i_proc.i_procAsserts.failCount, cycles);
      if (halted && errCount == 0 && i_proc.i_procAsserts.failCount == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- build.f
src/procPkg.sv
src/decodeBus.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/memory.sv
src/hazardCtrl.sv
src/proc.sv
bench/proc_asserts.sv
bench/procTb.sv

//--- Makefile
TOP := procTb
LOG := sim.log

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
